// ==== src.f ====
doe_pkg.sv
doe_sbox.sv
doe_key_mem.sv
doe_encipher_block.sv
doe_core.sv
tb_doe_core.sv

// ==== Bender.yml ====
package:
  name: doe_core

sources:
  - doe_pkg.sv
  - doe_sbox.sv
  - doe_key_mem.sv
  - doe_encipher_block.sv
  - doe_core.sv
  - target: test
    files:
      - tb_doe_core.sv

// ==== tb_doe_core.sv ====
/*
 * Testbench for the DOE cipher core
 * Known-answer vectors, encipher latency, busy strobe and result_valid checks
 */
`timescale 1ns/10ps

module tb_doe_core;

  // --------------------------------------------------
  // Run length
  // --------------------------------------------------
  localparam int reset_cycles    = 10;
  // Longest single operation is a 256-bit encipher
  localparam int max_op_cycles   = 2 + 5 * 14;
  // Three key loads and four blocks
  localparam int num_ops         = 7;
  localparam int watchdog_cycles = 4 * (reset_cycles + num_ops * max_op_cycles);

  // Standard known-answer vectors
  localparam logic [127:0] key_seq128 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] key_ex128  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [255:0] key_seq256 =
    256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
  localparam logic [127:0] pt_seq     = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] pt_ex      = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] ct_seq128  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] ct_ex128   = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam logic [127:0] ct_seq256  = 128'h8ea2b7ca516745bfeafc49904b496089;

  logic         clk;
  logic         reset_n;
  logic         init;
  logic         next;
  logic [255:0] key;
  logic         keylen;
  logic [127:0] block;
  logic         ready;
  logic [127:0] result;
  logic         result_valid;

  integer seed;

  doe_core doe_core_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .init         (init),
    .next         (next),
    .key          (key),
    .keylen       (keylen),
    .block        (block),
    .ready        (ready),
    .result       (result),
    .result_valid (result_valid)
  );

  // 4 ns period
  always
  begin
    #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic fail_value(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
    $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    $display("Test failed");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("Test failed");
    $fatal(1, "%s", what);
  endtask

  task automatic expect_eq(input string name, input logic [127:0] exp,
                           input logic [127:0] act);
    assert (act === exp)
      else fail_value(name, exp, act);
  endtask

  // Valid result only while idle
  valid_needs_ready: assert property (@(posedge clk) disable iff (!reset_n)
    result_valid |-> ready)
    else abort_run("result_valid is high while the core is busy");

  // Valid comes back together with ready
  valid_with_ready: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(result_valid) |-> $rose(ready))
    else abort_run("result_valid rose in a cycle where ready did not return");

  // --------------------------------------------------
  // Command sequences
  // --------------------------------------------------
  // Strobe init and wait for key expansion to finish
  task automatic load_key(input logic [255:0] k, input logic kl);
    logic [127:0] held;
    held   = result;
    key    = k;
    keylen = kl;
    init   = 1'b1;
    @(negedge clk);
    init = 1'b0;
    expect_eq("ready", 1'b0, ready);
    while (!ready)
    begin
      // Valid cleared and result kept during expansion
      expect_eq("result_valid", 1'b0, result_valid);
      expect_eq("result", held, result);
      @(negedge clk);
    end
    // A key load produces no ciphertext
    expect_eq("result_valid", 1'b0, result_valid);
    expect_eq("result", held, result);
  endtask

  // Encipher one block with optional ignored strobes while busy
  task automatic run_block(input logic [127:0] pt, input logic [127:0] ct,
                           input int exp_cycles, input bit strobe_busy);
    logic [127:0] held;
    int           cycles;
    held  = result;
    block = pt;
    next  = 1'b1;
    @(negedge clk);
    next   = 1'b0;
    cycles = 0;
    while (!ready)
    begin
      expect_eq("result_valid", 1'b0, result_valid);
      expect_eq("result", held, result);
      init  = 1'b0;
      next  = 1'b0;
      block = pt;
      // Busy strobes come well after the block is sampled in cycle 0
      if (strobe_busy && (cycles == 5 || cycles == 21 || cycles == 37))
      begin
        block = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if (cycles == 21)
          init = 1'b1;
        else
          next = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    init  = 1'b0;
    next  = 1'b0;
    block = pt;
    expect_eq("latency", exp_cycles, cycles);
    expect_eq("result_valid", 1'b1, result_valid);
    expect_eq("result", ct, result);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    seed    = 58;
    clk     = 1'b0;
    reset_n = 1'b0;
    init    = 1'b0;
    next    = 1'b0;
    key     = '0;
    keylen  = 1'b0;
    block   = '0;

    repeat (reset_cycles) @(negedge clk);
    // Values while in reset
    expect_eq("ready", 1'b1, ready);
    expect_eq("result_valid", 1'b0, result_valid);
    expect_eq("result", 128'h0, result);
    reset_n = 1'b1;
    @(negedge clk);
    expect_eq("ready", 1'b1, ready);
    expect_eq("result_valid", 1'b0, result_valid);
    expect_eq("result", 128'h0, result);

    // 128-bit sequential key with busy strobes on the second block
    load_key({key_seq128, 128'h0}, 1'b0);
    run_block(pt_seq, ct_seq128, 52, 1'b0);
    run_block(pt_seq, ct_seq128, 52, 1'b1);

    // 128-bit worked example
    load_key({key_ex128, 128'h0}, 1'b0);
    run_block(pt_ex, ct_ex128, 52, 1'b0);

    // 256-bit sequential key
    load_key(key_seq256, 1'b1);
    run_block(pt_seq, ct_seq256, 72, 1'b1);

    repeat (2) @(negedge clk);
    $display("Test passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: timeout, the core did not finish within %0d cycles", watchdog_cycles);
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== doe_core.sv ====
/*
 * DOE cipher core
 * Key expansion and encipher engine around one shared sbox,
 * with command gating, ready and result_valid
 */
`timescale 1ns/10ps

module doe_core (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         init,
  input  logic         next,
  input  logic [255:0] key,
  input  logic         keylen,
  input  logic [127:0] block,
  output logic         ready,
  output logic [127:0] result,
  output logic         result_valid
);
  import doe_pkg::*;

  logic         init_acc;
  logic         next_acc;
  logic         op_done;
  logic         key_ready;
  logic         enc_ready;
  logic [3:0]   enc_round;
  logic [127:0] round_key;
  logic [31:0]  key_sboxw;
  logic [31:0]  enc_sboxw;
  logic [31:0]  muxed_sboxw;
  logic [31:0]  new_sboxw;
  logic [127:0] enc_new_block;

  logic         ready_reg;
  logic         result_valid_reg;
  logic [127:0] result_reg;
  // Last accepted command was next
  logic         op_next_reg;

  // --------------------------------------------------
  // Command gating and sbox sharing
  // --------------------------------------------------
  // Strobes only count while idle, init wins a tie
  assign init_acc     = init & ready_reg;
  assign next_acc     = next & ready_reg & ~init;
  assign op_done      = ~ready_reg & key_ready & enc_ready;
  // Key expansion owns the sbox while it runs
  assign muxed_sboxw  = key_ready ? enc_sboxw : key_sboxw;
  assign ready        = ready_reg;
  assign result       = result_reg;
  assign result_valid = result_valid_reg;

  doe_key_mem key_mem_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .init      (init_acc),
    .key       (key),
    .keylen    (keylen),
    .round     (enc_round),
    .new_sboxw (new_sboxw),
    .round_key (round_key),
    .ready     (key_ready),
    .sboxw     (key_sboxw)
  );

  doe_encipher_block enc_block_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .next_cmd  (next_acc),
    .keylen    (keylen),
    .round_key (round_key),
    .new_sboxw (new_sboxw),
    .block_msg (block),
    .round     (enc_round),
    .sboxw     (enc_sboxw),
    .new_block (enc_new_block),
    .ready     (enc_ready)
  );

  doe_sbox sbox_i (
    .sboxw     (muxed_sboxw),
    .new_sboxw (new_sboxw)
  );

  // --------------------------------------------------
  // Ready, result and result_valid
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin : status_update
    if (!reset_n)
    begin
      ready_reg        <= 1'b1;
      result_valid_reg <= 1'b0;
      result_reg       <= 128'h0;
      op_next_reg      <= 1'b0;
    end
    else if (init_acc || next_acc)
    begin
      ready_reg        <= 1'b0;
      result_valid_reg <= 1'b0;
      op_next_reg      <= next_acc;
    end
    // Submodule ready came back, valid only after an encipher
    else if (op_done)
    begin
      ready_reg        <= 1'b1;
      result_valid_reg <= op_next_reg;
      if (op_next_reg)
        result_reg <= enc_new_block;
    end
  end

endmodule

// ==== doe_encipher_block.sv ====
/*
 * DOE encipher round engine
 * Iterative rounds with word-serial SubBytes through the shared sbox
 */
`timescale 1ns/10ps

module doe_encipher_block (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         next_cmd,
  input  logic         keylen,
  input  logic [127:0] round_key,
  input  logic [31:0]  new_sboxw,
  input  logic [127:0] block_msg,
  output logic [3:0]   round,
  output logic [31:0]  sboxw,
  output logic [127:0] new_block,
  output logic         ready
);
  import doe_pkg::*;

  // --------------------------------------------------
  // Round functions
  // --------------------------------------------------
  // Multiply by x in GF(2^8)
  function automatic logic [7:0] gm2(input logic [7:0] op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  function automatic logic [7:0] gm3(input logic [7:0] op);
    return gm2(op) ^ op;
  endfunction

  // One column through the MixColumns matrix
  function automatic logic [31:0] mixw(input logic [31:0] w);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    return {gm2(b0) ^ gm3(b1) ^ b2 ^ b3,
            b0 ^ gm2(b1) ^ gm3(b2) ^ b3,
            b0 ^ b1 ^ gm2(b2) ^ gm3(b3),
            gm3(b0) ^ b1 ^ b2 ^ gm2(b3)};
  endfunction

  function automatic logic [127:0] mixcolumns(input logic [127:0] d);
    return {mixw(d[127:96]), mixw(d[95:64]), mixw(d[63:32]), mixw(d[31:0])};
  endfunction

  // Row r rotates left by r columns
  function automatic logic [127:0] shiftrows(input logic [127:0] d);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    w0 = d[127:96];
    w1 = d[95:64];
    w2 = d[63:32];
    w3 = d[31:0];
    return {w0[31:24], w1[23:16], w2[15:8], w3[7:0],
            w1[31:24], w2[23:16], w3[15:8], w0[7:0],
            w2[31:24], w3[23:16], w0[15:8], w1[7:0],
            w3[31:24], w0[23:16], w1[15:8], w2[7:0]};
  endfunction

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  // State words, word 0 is the leftmost column
  logic [31:0] block_w_reg [0:3];
  logic [1:0]  sword_ctr_reg;
  logic [3:0]  round_ctr_reg;
  logic        ready_reg;
  enc_ctrl_t   enc_ctrl_reg;

  logic [127:0] block_new;
  logic [3:0]   block_we;
  logic [1:0]   sword_ctr_new;
  logic [3:0]   round_ctr_new;
  logic         ready_new;
  enc_ctrl_t    enc_ctrl_new;
  update_t      update;

  assign round     = round_ctr_reg;
  assign ready     = ready_reg;
  assign new_block = {block_w_reg[0], block_w_reg[1], block_w_reg[2], block_w_reg[3]};

  // --------------------------------------------------
  // Round datapath
  // --------------------------------------------------
  always_comb
  begin : round_logic
    logic [127:0] shifted;
    logic [127:0] mixed;
    shifted   = shiftrows(new_block);
    mixed     = mixcolumns(shifted);
    block_new = '0;
    block_we  = 4'b0000;
    // Current word offered to the sbox
    sboxw     = block_w_reg[sword_ctr_reg];
    case (update)
      init_update:
      begin
        block_new = block_msg ^ round_key;
        block_we  = 4'b1111;
      end
      sbox_update:
      begin
        block_new               = {4{new_sboxw}};
        block_we[sword_ctr_reg] = 1'b1;
      end
      main_update:
      begin
        block_new = mixed ^ round_key;
        block_we  = 4'b1111;
      end
      // Last round skips MixColumns
      final_update:
      begin
        block_new = shifted ^ round_key;
        block_we  = 4'b1111;
      end
      default:
        block_we = 4'b0000;
    endcase
  end

  // --------------------------------------------------
  // Encipher FSM
  // --------------------------------------------------
  always_comb
  begin : encipher_ctrl
    logic [3:0] num_rounds;
    num_rounds    = (keylen == DOE_256_BIT_KEY) ? DOE256_ROUNDS : DOE128_ROUNDS;
    update        = no_update;
    enc_ctrl_new  = enc_ctrl_reg;
    sword_ctr_new = sword_ctr_reg;
    round_ctr_new = round_ctr_reg;
    ready_new     = ready_reg;
    case (enc_ctrl_reg)
      ctrl_idle:
        if (next_cmd)
        begin
          round_ctr_new = 4'd0;
          ready_new     = 1'b0;
          enc_ctrl_new  = ctrl_init;
        end
      // Whitening with round key 0
      ctrl_init:
      begin
        update        = init_update;
        round_ctr_new = round_ctr_reg + 4'd1;
        sword_ctr_new = 2'd0;
        enc_ctrl_new  = ctrl_sbox;
      end
      // One state word per cycle
      ctrl_sbox:
      begin
        update        = sbox_update;
        sword_ctr_new = sword_ctr_reg + 2'd1;
        if (sword_ctr_reg == 2'd3)
          enc_ctrl_new = ctrl_main;
      end
      ctrl_main:
      begin
        sword_ctr_new = 2'd0;
        if (round_ctr_reg < num_rounds)
        begin
          update        = main_update;
          round_ctr_new = round_ctr_reg + 4'd1;
          enc_ctrl_new  = ctrl_sbox;
        end
        else
        begin
          update       = final_update;
          ready_new    = 1'b1;
          enc_ctrl_new = ctrl_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin : ctrl_update
    if (!reset_n)
    begin
      sword_ctr_reg <= 2'd0;
      round_ctr_reg <= 4'd0;
      ready_reg     <= 1'b1;
      enc_ctrl_reg  <= ctrl_idle;
    end
    else
    begin
      sword_ctr_reg <= sword_ctr_new;
      round_ctr_reg <= round_ctr_new;
      ready_reg     <= ready_new;
      enc_ctrl_reg  <= enc_ctrl_new;
    end
  end

  // State words
  always_ff @(posedge clk)
  begin : block_update
    for (int i = 0; i < 4; i++)
    begin
      if (block_we[i])
        block_w_reg[i] <= block_new[127 - 32*i -: 32];
    end
  end

endmodule

// ==== doe_key_mem.sv ====
/*
 * DOE key memory
 * Expands a 128-bit or 256-bit key, one round key per cycle,
 * and serves the round keys by round number
 */
`timescale 1ns/10ps

module doe_key_mem (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         init,
  input  logic [255:0] key,
  input  logic         keylen,
  input  logic [3:0]   round,
  input  logic [31:0]  new_sboxw,
  output logic [127:0] round_key,
  output logic         ready,
  output logic [31:0]  sboxw
);
  import doe_pkg::*;

  // --------------------------------------------------
  // Storage and state
  // --------------------------------------------------
  // Round keys 0 to 14
  logic [127:0] key_mem [0:14];
  logic [255:0] key_reg;
  // Two keys back and one key back
  logic [127:0] prev_key0_reg;
  logic [127:0] prev_key1_reg;
  logic [7:0]   rcon_reg;
  logic [3:0]   round_ctr_reg;
  logic         ready_reg;
  key_ctrl_t    key_ctrl_reg;

  logic [3:0]   num_rounds;
  logic [127:0] gen_key;
  logic         rcon_step;

  assign round_key  = key_mem[round];
  assign ready      = ready_reg;
  // Last word of the newest key goes through the shared sbox
  assign sboxw      = prev_key1_reg[31:0];
  assign num_rounds = (keylen == DOE_256_BIT_KEY) ? DOE256_ROUNDS : DOE128_ROUNDS;

  // --------------------------------------------------
  // Next round key
  // --------------------------------------------------
  always_comb
  begin : key_gen
    logic [127:0] base;
    logic [31:0]  t;
    logic [31:0]  w0;
    logic [31:0]  w1;
    logic [31:0]  w2;
    logic [31:0]  w3;
    logic         use_rcon;
    logic         from_key;
    // 256-bit keys alternate: even keys rotate and add rcon, odd keys only substitute
    use_rcon = (keylen != DOE_256_BIT_KEY) || !round_ctr_reg[0];
    from_key = (round_ctr_reg == 4'd0) ||
               ((round_ctr_reg == 4'd1) && (keylen == DOE_256_BIT_KEY));
    if (use_rcon)
      t = {new_sboxw[23:0], new_sboxw[31:24]} ^ {rcon_reg, 24'h0};
    else
      t = new_sboxw;
    // Nk = 8 works from two keys back, Nk = 4 from one key back
    base = (keylen == DOE_256_BIT_KEY) ? prev_key0_reg : prev_key1_reg;
    w0   = base[127:96] ^ t;
    w1   = base[95:64] ^ w0;
    w2   = base[63:32] ^ w1;
    w3   = base[31:0] ^ w2;
    if (round_ctr_reg == 4'd0)
      gen_key = key_reg[255:128];
    else if (from_key)
      gen_key = key_reg[127:0];
    else
      gen_key = {w0, w1, w2, w3};
    rcon_step = use_rcon && !from_key && (key_ctrl_reg == key_generate);
  end

  // --------------------------------------------------
  // Key expansion FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin : key_ctrl
    if (!reset_n)
    begin
      ready_reg     <= 1'b1;
      round_ctr_reg <= 4'd0;
      rcon_reg      <= 8'h01;
      key_ctrl_reg  <= key_idle;
    end
    else
    begin
      case (key_ctrl_reg)
        key_idle:
          if (init)
          begin
            ready_reg    <= 1'b0;
            key_ctrl_reg <= key_init;
          end
        key_init:
        begin
          round_ctr_reg <= 4'd0;
          rcon_reg      <= 8'h01;
          key_ctrl_reg  <= key_generate;
        end
        key_generate:
        begin
          // Round constant doubles in the field after each use
          if (rcon_step)
            rcon_reg <= {rcon_reg[6:0], 1'b0} ^ (8'h1b & {8{rcon_reg[7]}});
          if (round_ctr_reg == num_rounds)
            key_ctrl_reg <= key_done;
          else
            round_ctr_reg <= round_ctr_reg + 4'd1;
        end
        key_done:
        begin
          ready_reg    <= 1'b1;
          key_ctrl_reg <= key_idle;
        end
      endcase
    end
  end

  // Key latch and round key writes
  always_ff @(posedge clk)
  begin : key_store
    if ((key_ctrl_reg == key_idle) && init)
      key_reg <= key;
    if (key_ctrl_reg == key_generate)
    begin
      key_mem[round_ctr_reg] <= gen_key;
      prev_key0_reg          <= prev_key1_reg;
      prev_key1_reg          <= gen_key;
    end
  end

endmodule

// ==== doe_sbox.sv ====
/*
 * DOE substitution box, four bytes per evaluation
 * Each byte maps to its GF(2^8) inverse followed by the affine transform
 */
`timescale 1ns/10ps

module doe_sbox (
  input  logic [31:0] sboxw,
  output logic [31:0] new_sboxw
);
  import doe_pkg::*;

  // Field multiply, reduction polynomial x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ sh;
      // xtime step
      sh = {sh[6:0], 1'b0} ^ (8'h1b & {8{sh[7]}});
    end
    return acc;
  endfunction

  // Inverse as a^254, zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] a2;
    logic [7:0] a3;
    logic [7:0] a12;
    logic [7:0] t;
    a2  = gf_mul(a, a);
    a3  = gf_mul(a2, a);
    t   = gf_mul(a3, a3);
    a12 = gf_mul(t, t);
    // a^15, then four squarings give a^240
    t   = gf_mul(a12, a3);
    t   = gf_mul(t, t);
    t   = gf_mul(t, t);
    t   = gf_mul(t, t);
    t   = gf_mul(t, t);
    // 240 + 12 + 2
    t   = gf_mul(t, a12);
    return gf_mul(t, a2);
  endfunction

  // Affine map over GF(2) plus constant 0x63
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [7:0] x;
    x = gf_inv(b);
    return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^
           {x[3:0], x[7:4]} ^ 8'h63;
  endfunction

  always_comb
  begin
    for (int i = 0; i < 4; i++)
      new_sboxw[8*i +: 8] = sub_byte(sboxw[8*i +: 8]);
  end

endmodule

// ==== doe_pkg.sv ====
/*
 * DOE cipher package
 * Round counts, key length code and FSM encodings shared by the core
 */
package doe_pkg;

  // --------------------------------------------------
  // Key schedule constants
  // --------------------------------------------------
  // Rounds for a 128-bit key
  localparam logic [3:0] DOE128_ROUNDS = 4'ha;
  // Rounds for a 256-bit key
  localparam logic [3:0] DOE256_ROUNDS = 4'he;

  // keylen code for 256 bits, code 0 is a 128-bit key
  localparam logic DOE_256_BIT_KEY = 1'b1;

  // --------------------------------------------------
  // FSM and datapath select encodings
  // --------------------------------------------------
  // Encipher round engine states
  typedef enum logic [1:0] {
    ctrl_idle = 2'h0,
    ctrl_init = 2'h1,
    ctrl_sbox = 2'h2,
    ctrl_main = 2'h3
  } enc_ctrl_t;

  // What the encipher state register loads this cycle
  typedef enum logic [2:0] {
    no_update    = 3'h0,
    init_update  = 3'h1,
    sbox_update  = 3'h2,
    main_update  = 3'h3,
    final_update = 3'h4
  } update_t;

  // Key expansion FSM states
  typedef enum logic [1:0] {
    key_idle     = 2'h0,
    key_init     = 2'h1,
    key_generate = 2'h2,
    key_done     = 2'h3
  } key_ctrl_t;

endpackage
